/* verilog/rf_pkg.sv */
//--------------------------------------------------
// Register file shared definitions
//
// Sizes, vector types, port structs and the power
// sequencer state encoding for the power-gated
// 4x157 register file subsystem
//--------------------------------------------------

package rf_pkg;

    //--------------------------------------------------
    // Sizes
    //--------------------------------------------------

    // Number of entries in the register file
    localparam int rf_depth = 4;

    // Address width for four entries
    localparam int rf_addr_w = 2;

    // Functional data width seen at the subsystem ports
    localparam int rf_width = 157;

    // Physical array width, one pad bit above the functional data
    localparam int rf_store_w = 158;

    // Flops in the power-enable daisy chain through the array
    localparam int pwr_chain_len = 2;

    //--------------------------------------------------
    // Vector types
    //--------------------------------------------------

    typedef logic [rf_addr_w-1:0]  rf_addr_t;
    typedef logic [rf_width-1:0]   rf_data_t;
    typedef logic [rf_store_w-1:0] rf_word_t;

    //--------------------------------------------------
    // Port structs
    //--------------------------------------------------

    // Write port, a single-cycle strobe with address and data
    typedef struct packed {
        logic     we;
        rf_addr_t waddr;
        rf_data_t wdata;
    } rf_wr_t;

    // Read port, a single-cycle strobe with address
    typedef struct packed {
        logic     re;
        rf_addr_t raddr;
    } rf_rd_t;

    // Power controls from the sequencer to the array
    // pwr_enable_b is active low, high means the array is unpowered
    typedef struct packed {
        logic isol_en;
        logic pwr_enable_b;
    } rf_pwr_t;

    // Power sequencer states, in the order they are visited
    typedef enum logic [2:0] {
        pg_on,
        pg_isolate,
        pg_off,
        pg_power_up,
        pg_deisolate
    } pg_state_t;

endpackage

/* verilog/mem_reset_sync_scan.sv */
//--------------------------------------------------
// Reset synchronizer with scan bypass
//
// Two flops assert reset at once and release it
// on the second clock edge; scan can override
//--------------------------------------------------

`timescale 1ns/1ns

module mem_reset_sync_scan (
    input  logic clk,
    input  logic reset,
    input  logic fscan_rstbypen,
    input  logic fscan_byprst,
    output logic reset_sync
);

    // Synchronizer stages, bit 1 is the output stage
    logic [1:0] sync_q;

    // Reset sets both stages right away so the array sees it without a clock
    // Release shifts zeros in, so the output drops two clk edges later
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_q <= 2'b11;
        end else begin
            sync_q <= {sync_q[0], 1'b0};
        end
    end

    // In scan mode the tester owns the reset value directly
    assign reset_sync = fscan_rstbypen ? fscan_byprst : sync_q[1];

endmodule

/* verilog/rf_array_4x158.sv */
//--------------------------------------------------
// Behavioral 4x158 two-port register file array
//
// Write port on wclk, registered read port on rclk
// Writes are blocked under isolation or power-off,
// the read output is clamped under isolation, and
// contents are lost while the array is unpowered
// A short flop chain models the power switch delay
//--------------------------------------------------

`timescale 1ns/1ns

module rf_array_4x158 import rf_pkg::*; (
    input  logic     wclk,
    input  logic     rclk,
    input  logic     reset,
    input  logic     we,
    input  rf_addr_t waddr,
    input  rf_word_t wdata,
    input  logic     re,
    input  rf_addr_t raddr,
    input  logic     isol_en,
    input  logic     pwr_enable_b,
    output logic     pwr_enable_b_out,
    output rf_word_t rdata
);

    //--------------------------------------------------
    // Storage
    //--------------------------------------------------

    rf_word_t mem [rf_depth];

    // Read data register, holds its value while re is low
    rf_word_t rd_q;

    // Power-enable daisy chain, entry 0 is nearest the input
    logic [pwr_chain_len-1:0] pwr_chain_q;

    // Write is accepted only with the array powered, not isolated and out of reset
    logic wr_ok;

    assign wr_ok = we && !isol_en && !pwr_enable_b && !reset;

    //--------------------------------------------------
    // Write port
    //--------------------------------------------------

    // An unpowered array loses its contents, modeled here as all zero
    // Reset comes from the rclk synchronizer and clears the entries as well
    always_ff @(posedge wclk) begin
        if (reset || pwr_enable_b) begin
            for (int i = 0; i < rf_depth; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_ok) begin
            mem[waddr] <= wdata;
        end
    end

    //--------------------------------------------------
    // Read port
    //--------------------------------------------------

    // The read samples the array before a same-edge write lands,
    // so a read and write of one entry together return the old word
    // The output register sits in the gated domain and drops to zero
    // with the power
    always_ff @(posedge rclk) begin
        if (reset || pwr_enable_b) begin
            rd_q <= '0;
        end else if (re) begin
            rd_q <= mem[raddr];
        end
    end

    // Isolation clamps the output so the outside never sees a floating array
    assign rdata = isol_en ? '0 : rd_q;

    //--------------------------------------------------
    // Power switch chain
    //--------------------------------------------------

    // The enable ripples through the switch segments one flop per cycle
    always_ff @(posedge rclk) begin
        if (reset) begin
            pwr_chain_q <= '0;
        end else begin
            pwr_chain_q <= {pwr_chain_q[pwr_chain_len-2:0], pwr_enable_b};
        end
    end

    // End of the chain, this is the acknowledge the sequencer waits on
    assign pwr_enable_b_out = pwr_chain_q[pwr_chain_len-1];

endmodule

/* verilog/rf_pg_4x157.sv */
//--------------------------------------------------
// Power-gated 4x157 register file wrapper
//
// Maps the 157-bit functional word onto the 158-bit
// array with a zero pad bit and synchronizes the
// array reset to rclk with scan bypass
//--------------------------------------------------

`timescale 1ns/1ns

module rf_pg_4x157 import rf_pkg::*; (
    input  logic     wclk,
    input  logic     rclk,
    input  logic     reset,
    input  rf_wr_t   wr,
    input  rf_rd_t   rd,
    input  rf_pwr_t  pwr,
    output logic     pwr_enable_b_out,
    input  logic     fscan_rstbypen,
    input  logic     fscan_byprst,
    output rf_data_t rdata
);

    // Array reset after the synchronizer or the scan override
    logic reset_sync;

    // Full-width read word from the array
    rf_word_t rdata_store;

    mem_reset_sync_scan u_reset_sync (
        .clk            (rclk),
        .reset          (reset),
        .fscan_rstbypen (fscan_rstbypen),
        .fscan_byprst   (fscan_byprst),
        .reset_sync     (reset_sync)
    );

    //--------------------------------------------------
    // Array
    //--------------------------------------------------

    // The top bit of the physical word is unused and always written as zero
    rf_array_4x158 u_array (
        .wclk             (wclk),
        .rclk             (rclk),
        .reset            (reset_sync),
        .we               (wr.we),
        .waddr            (wr.waddr),
        .wdata            ({1'b0, wr.wdata}),
        .re               (rd.re),
        .raddr            (rd.raddr),
        .isol_en          (pwr.isol_en),
        .pwr_enable_b     (pwr.pwr_enable_b),
        .pwr_enable_b_out (pwr_enable_b_out),
        .rdata            (rdata_store)
    );

    // Drop the pad bit on the way out
    assign rdata = rdata_store[rf_width-1:0];

    // The pad bit is only ever written as zero, so a one here means
    // the array returned a word it was never given
    pad_bit_zero_a: assert property (
        @(posedge rclk) disable iff (reset_sync)
        !rdata_store[rf_store_w-1]
    ) else $error("Pad bit of the register file array read back as one");

endmodule

/* verilog/rf_pwr_seq.sv */
//--------------------------------------------------
// Register file power-gating sequencer
//
// Isolates the array before removing power, and
// restores power and waits for the switch chain
// acknowledge before releasing isolation
//--------------------------------------------------

`timescale 1ns/1ns

module rf_pwr_seq import rf_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    sleep_req,
    input  logic    pwr_enable_b_out,
    output rf_pwr_t pwr,
    output logic    ready
);

    pg_state_t state_q;
    pg_state_t state_d;

    //--------------------------------------------------
    // State register
    //--------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= pg_on;
        end else begin
            state_q <= state_d;
        end
    end

    //--------------------------------------------------
    // Next state
    //--------------------------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            // Normal operation until sleep is requested
            pg_on: begin
                if (sleep_req) begin
                    state_d = pg_isolate;
                end
            end
            // One cycle with the clamp applied before power goes away
            pg_isolate: begin
                state_d = pg_off;
            end
            // Array unpowered, stay here as long as the request is held
            pg_off: begin
                if (!sleep_req) begin
                    state_d = pg_power_up;
                end
            end
            // Power is back on, wait for the end of the switch chain
            pg_power_up: begin
                if (!pwr_enable_b_out) begin
                    state_d = pg_deisolate;
                end
            end
            // Clamp released, one settling cycle before ready
            pg_deisolate: begin
                state_d = pg_on;
            end
            default: begin
                state_d = pg_on;
            end
        endcase
    end

    //--------------------------------------------------
    // Outputs
    //--------------------------------------------------

    // Isolation covers every state in which power is off or still ramping
    always_comb begin
        pwr.isol_en      = 1'b0;
        pwr.pwr_enable_b = 1'b0;
        case (state_q)
            pg_isolate: begin
                pwr.isol_en = 1'b1;
            end
            pg_off: begin
                pwr.isol_en      = 1'b1;
                pwr.pwr_enable_b = 1'b1;
            end
            pg_power_up: begin
                pwr.isol_en = 1'b1;
            end
            default: begin
                pwr.isol_en      = 1'b0;
                pwr.pwr_enable_b = 1'b0;
            end
        endcase
    end

    // The register file is usable only in the fully powered state
    assign ready = (state_q == pg_on);

    //--------------------------------------------------
    // Checks
    //--------------------------------------------------

    // Power may only be removed once isolation has already been up a cycle,
    // and it stays isolated for the whole off period
    isol_before_off_a: assert property (
        @(posedge clk) disable iff (reset)
        pwr.pwr_enable_b |-> pwr.isol_en && $past(pwr.isol_en)
    ) else $error("Array unpowered without isolation in place");

    // The chain acknowledge has to come back within 16 cycles of power-up
    pwr_up_timeout_a: assert property (
        @(posedge clk) disable iff (reset)
        $rose(state_q == pg_power_up) |-> ##[1:16] (state_q != pg_power_up)
    ) else $error("Power switch chain did not acknowledge power-up in time");

endmodule

/* verilog/rf_pg_top.sv */
//--------------------------------------------------
// Power-gated register file subsystem top
//
// Joins the power sequencer to the 4x157 wrapper
// and closes the power-enable acknowledge loop
//--------------------------------------------------

`timescale 1ns/1ns

module rf_pg_top import rf_pkg::*; (
    input  logic     wclk,
    input  logic     rclk,
    input  logic     reset,
    input  rf_wr_t   wr,
    input  rf_rd_t   rd,
    input  logic     sleep_req,
    input  logic     fscan_rstbypen,
    input  logic     fscan_byprst,
    output rf_data_t rdata,
    output logic     ready
);

    // Isolation and power enable from the sequencer
    rf_pwr_t pwr;

    // Far end of the array power chain, back to the sequencer
    logic pwr_enable_b_out;

    // The sequencer runs on the read clock, same as the array reset
    rf_pwr_seq u_pwr_seq (
        .clk              (rclk),
        .reset            (reset),
        .sleep_req        (sleep_req),
        .pwr_enable_b_out (pwr_enable_b_out),
        .pwr              (pwr),
        .ready            (ready)
    );

    rf_pg_4x157 u_rf (
        .wclk             (wclk),
        .rclk             (rclk),
        .reset            (reset),
        .wr               (wr),
        .rd               (rd),
        .pwr              (pwr),
        .pwr_enable_b_out (pwr_enable_b_out),
        .fscan_rstbypen   (fscan_rstbypen),
        .fscan_byprst     (fscan_byprst),
        .rdata            (rdata)
    );

endmodule

/* test/rf_pg_tb.sv */
//--------------------------------------------------
// Power-gated register file testbench
//
// Runs operations from the vector file against the
// subsystem top and checks each read against the
// vector file and a reference array model
//--------------------------------------------------

`timescale 1ns/1ns

module rf_pg_tb import rf_pkg::*; ();

    // One clock drives both ports, so no crossing is exercised
    logic     clk = 1'b0;
    logic     reset;
    rf_wr_t   wr;
    rf_rd_t   rd;
    logic     sleep_req;
    logic     fscan_rstbypen;
    logic     fscan_byprst;
    rf_data_t rdata;
    logic     ready;

    // Reference model of the entries and the read register
    rf_data_t ref_mem [rf_depth];
    rf_data_t ref_rdata;
    logic     asleep;

    // Vector file parsing state
    integer           fd;
    integer           code;
    integer           vec_no;
    integer           seed;
    logic             done;
    logic [7:0]       op_char;
    logic [8*128-1:0] skip_line;
    rf_addr_t         addr_f;
    rf_data_t         data_f;
    rf_data_t         exp_f;
    string            name;

    always #50 clk = ~clk;

    rf_pg_top u_rf_pg_top (
        .wclk           (clk),
        .rclk           (clk),
        .reset          (reset),
        .wr             (wr),
        .rd             (rd),
        .sleep_req      (sleep_req),
        .fscan_rstbypen (fscan_rstbypen),
        .fscan_byprst   (fscan_byprst),
        .rdata          (rdata),
        .ready          (ready)
    );

    //--------------------------------------------------
    // Checking helpers
    //--------------------------------------------------

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_value(input string test_name, input rf_data_t expected,
                               input rf_data_t actual);
        if (actual !== expected) begin
            stop_on_failure($sformatf("[ERROR] %s expected %h actual %h",
                                      test_name, expected, actual));
        end
    endtask

    // Widens a status bit to the data width
    function automatic rf_data_t widen_bit(input logic b);
        rf_data_t w;
        w = '0;
        w[0] = b;
        return w;
    endfunction

    // Five draws cover the 157-bit word and the spare top bits are dropped
    task automatic random_word(output rf_data_t w);
        logic [159:0] raw;
        raw = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
        w = raw[rf_width-1:0];
    endtask

    // Polls ready at falling edges until it reaches the level or 32 cycles pass
    task automatic wait_ready_level(input logic level, input string what);
        integer cycles;
        cycles = 0;
        while (ready !== level && cycles < 32) begin
            @(negedge clk);
            cycles++;
        end
        if (ready !== level) begin
            stop_on_failure(what);
        end
    endtask

    //--------------------------------------------------
    // Operations entered and left at a falling edge
    //--------------------------------------------------

    // Writes are lost while the array sleeps, so the model skips them
    task automatic write_entry(input rf_addr_t addr, input rf_data_t data);
        wr.we    = 1'b1;
        wr.waddr = addr;
        wr.wdata = data;
        @(negedge clk);
        wr.we = 1'b0;
        if (!asleep) begin
            ref_mem[addr] = data;
        end
    endtask

    // Read data is registered, so it is sampled one falling edge after re
    task automatic read_entry(input rf_addr_t addr, input rf_data_t exp_vec,
                              input string test_name);
        rd.re    = 1'b1;
        rd.raddr = addr;
        @(negedge clk);
        rd.re = 1'b0;
        ref_rdata = asleep ? '0 : ref_mem[addr];
        check_value($sformatf("%s vector", test_name), exp_vec, rdata);
        check_value($sformatf("%s model", test_name), ref_rdata, rdata);
    endtask

    // With re low the read register keeps its last word even when the address moves
    task automatic hold_and_check(input rf_addr_t addr, input rf_data_t exp_vec,
                                  input string test_name);
        rd.raddr = addr;
        repeat (3) @(negedge clk);
        check_value($sformatf("%s vector", test_name), exp_vec, rdata);
        check_value($sformatf("%s model", test_name), ref_rdata, rdata);
    endtask

    // A read and a write of one entry on the same edge return the old word
    task automatic read_write_same(input rf_addr_t addr, input rf_data_t data,
                                   input rf_data_t exp_vec, input string test_name);
        wr.we    = 1'b1;
        wr.waddr = addr;
        wr.wdata = data;
        rd.re    = 1'b1;
        rd.raddr = addr;
        @(negedge clk);
        wr.we = 1'b0;
        rd.re = 1'b0;
        ref_rdata = asleep ? '0 : ref_mem[addr];
        if (!asleep) begin
            ref_mem[addr] = data;
        end
        check_value($sformatf("%s vector", test_name), exp_vec, rdata);
        check_value($sformatf("%s model", test_name), ref_rdata, rdata);
    endtask

    // Isolate takes one cycle, then the first edge in the off state clears the array
    // The read register still holds its word while isolated, so the clamp is visible
    task automatic enter_sleep(input string test_name);
        sleep_req = 1'b1;
        wait_ready_level(1'b0, "ready never dropped after the sleep request");
        check_value($sformatf("%s isolated", test_name), '0, rdata);
        repeat (2) @(negedge clk);
        asleep = 1'b1;
        ref_rdata = '0;
        for (int i = 0; i < rf_depth; i++) begin
            ref_mem[i] = '0;
        end
        check_value($sformatf("%s ready", test_name), widen_bit(1'b0), widen_bit(ready));
    endtask

    // Wake length depends on the power chain, so only ready rising ends it
    task automatic wake_up(input string test_name);
        sleep_req = 1'b0;
        wait_ready_level(1'b1, "ready never returned after the sleep request was cleared");
        asleep = 1'b0;
        ref_rdata = '0;
        check_value($sformatf("%s rdata", test_name), ref_rdata, rdata);
    endtask

    task automatic random_write_read(input rf_addr_t addr, input string test_name);
        rf_data_t data;
        random_word(data);
        write_entry(addr, data);
        read_entry(addr, data, test_name);
    endtask

    // Scan bypass holds the array out of reset while the external reset is high
    // The synchronizer is allowed to release before the bypass is removed
    task automatic scan_bypass_write(input rf_addr_t addr, input rf_data_t data,
                                     input rf_data_t exp_vec, input string test_name);
        fscan_rstbypen = 1'b1;
        fscan_byprst   = 1'b0;
        reset          = 1'b1;
        @(negedge clk);
        write_entry(addr, data);
        read_entry(addr, exp_vec, test_name);
        reset = 1'b0;
        repeat (2) @(negedge clk);
        fscan_rstbypen = 1'b0;
        @(negedge clk);
        check_value($sformatf("%s ready", test_name), widen_bit(1'b1), widen_bit(ready));
    endtask

    //--------------------------------------------------
    // Main sequence
    //--------------------------------------------------

    initial begin
        seed           = 32'h39f889aa;
        reset          = 1'b1;
        wr             = '0;
        rd             = '0;
        sleep_req      = 1'b0;
        fscan_rstbypen = 1'b0;
        fscan_byprst   = 1'b0;
        asleep         = 1'b0;
        ref_rdata      = '0;
        vec_no         = 0;
        done           = 1'b0;
        for (int i = 0; i < rf_depth; i++) begin
            ref_mem[i] = '0;
        end

        fd = $fopen("test/rf_vectors.txt", "r");
        if (fd == 0) begin
            stop_on_failure("Could not open the vector file test/rf_vectors.txt");
        end

        // Four cycles of reset, then two more for the array reset synchronizer
        repeat (4) @(negedge clk);
        reset = 1'b0;
        repeat (2) @(negedge clk);
        check_value("ready after reset", widen_bit(1'b1), widen_bit(ready));

        while (!done) begin
            code = $fscanf(fd, " %c", op_char);
            if (code != 1) begin
                done = 1'b1;
            end else if (op_char == "#") begin
                code = $fgets(skip_line, fd);
            end else begin
                code = $fscanf(fd, "%h %h %h", addr_f, data_f, exp_f);
                vec_no++;
                if (code != 3) begin
                    stop_on_failure($sformatf("Vector %0d in the vector file is malformed",
                                              vec_no));
                end
                name = $sformatf("vector %0d %c", vec_no, op_char);
                case (op_char)
                    "W": write_entry(addr_f, data_f);
                    "R": read_entry(addr_f, exp_f, name);
                    "H": hold_and_check(addr_f, exp_f, name);
                    "B": read_write_same(addr_f, data_f, exp_f, name);
                    "S": enter_sleep(name);
                    "K": wake_up(name);
                    "N": random_write_read(addr_f, name);
                    "P": scan_bypass_write(addr_f, data_f, exp_f, name);
                    default: begin
                        stop_on_failure($sformatf("Vector %0d has an unknown operation %c",
                                                  vec_no, op_char));
                    end
                endcase
            end
        end
        $fclose(fd);

        if (vec_no == 0) begin
            stop_on_failure("The vector file held no operations");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

/* filelist.f */
verilog/rf_pkg.sv
verilog/mem_reset_sync_scan.sv
verilog/rf_array_4x158.sv
verilog/rf_pg_4x157.sv
verilog/rf_pwr_seq.sv
verilog/rf_pg_top.sv
test/rf_pg_tb.sv

/* test/rf_vectors.txt */
# Columns: op addr data expected, with data and expected in hex
# Ops: W write, R read, H hold, B read+write, S sleep, K wake, N random, P scan bypass
R 0 0 0
R 1 0 0
R 2 0 0
R 3 0 0
W 0 0123456789abcdef0123456789abcdef 0
W 1 1fffffffffffffffffffffffffffffffffffffff 0
W 2 1000000000000000000000000000000000000000 0
W 3 0a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a 0
R 0 0 0123456789abcdef0123456789abcdef
R 1 0 1fffffffffffffffffffffffffffffffffffffff
R 2 0 1000000000000000000000000000000000000000
R 3 0 0a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a
H 0 0 0a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a
B 0 00000000deadbeef 0123456789abcdef0123456789abcdef
R 0 0 00000000deadbeef
S 0 0 0
R 1 0 0
W 1 000000000000cafe 0
R 1 0 0
K 0 0 0
R 0 0 0
R 1 0 0
R 2 0 0
R 3 0 0
N 0 0 0
N 1 0 0
N 2 0 0
N 3 0 0
S 0 0 0
K 0 0 0
R 0 0 0
R 2 0 0
N 1 0 0
N 3 0 0
P 2 000000000feedface 000000000feedface
R 2 0 000000000feedface
